// ==== muldiv_macros.svh ====
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// width of one integer operand or result
`define MULDIV_XLEN 64

// width of the tag that follows an instruction through the unit
// results may come back out of order, so the issue stage matches them by this id
`define MULDIV_TRANS_ID_BITS 3

`endif

// ==== muldiv_pkg.sv ====
`default_nettype none

`include "muldiv_macros.svh"

package muldiv_pkg;

  // --------------------
  // data types
  // --------------------
  // one operand or one result
  typedef logic [`MULDIV_XLEN-1:0] xlen_t;
  // instruction tag handed back with the result
  typedef logic [`MULDIV_TRANS_ID_BITS-1:0] trans_id_t;

  // --------------------
  // operation codes
  // --------------------
  // multiply group first, then divide and remainder group
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHU  = 4'd2,
    MULHSU = 4'd3,
    MULW   = 4'd4,
    DIV    = 4'd5,
    DIVU   = 4'd6,
    DIVW   = 4'd7,
    DIVUW  = 4'd8,
    REM    = 4'd9,
    REMU   = 4'd10,
    REMW   = 4'd11,
    REMUW  = 4'd12
  } fu_op_t;

  // serial divider states
  // idle waits for work, divide produces one quotient bit per cycle,
  // finish holds the corrected result until it is taken
  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } div_state_t;

endpackage

`default_nettype wire

// ==== multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module multiplier (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mult_valid_i,
  input  muldiv_pkg::fu_op_t    operation_i,
  input  muldiv_pkg::xlen_t     operand_a_i,
  input  muldiv_pkg::xlen_t     operand_b_i,
  input  muldiv_pkg::trans_id_t trans_id_i,
  output logic                  mult_valid_o,
  output muldiv_pkg::xlen_t     result_o,
  output muldiv_pkg::trans_id_t mult_trans_id_o
);

  // operand sign bits picked per operation
  logic                        sign_a;
  logic                        sign_b;
  // stage one registers
  logic                        valid_q;
  muldiv_pkg::fu_op_t          op_q;
  muldiv_pkg::trans_id_t       id_q;
  logic [`MULDIV_XLEN:0]       opa_q;
  logic [`MULDIV_XLEN:0]       opb_q;
  // full product of the two extended operands
  logic [2*`MULDIV_XLEN+1:0]   product;
  muldiv_pkg::xlen_t           result_d;

  // --------------------
  // stage one
  // --------------------
  // extend each operand by one bit so a single signed multiply covers
  // the signed, unsigned and mixed forms
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    unique case (operation_i)
      // signed by signed
      muldiv_pkg::MULH: begin
        sign_a = operand_a_i[`MULDIV_XLEN-1];
        sign_b = operand_b_i[`MULDIV_XLEN-1];
      end
      // signed rs1 by unsigned rs2
      muldiv_pkg::MULHSU: begin
        sign_a = operand_a_i[`MULDIV_XLEN-1];
      end
      // low half does not depend on the extension
      default: begin
      end
    endcase
  end

  // valid bit of stage one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mult_valid_i;
    end
  end

  // operands only load on an issue
  always_ff @(posedge clk_i) begin
    if (mult_valid_i) begin
      opa_q <= {sign_a, operand_a_i};
      opb_q <= {sign_b, operand_b_i};
      op_q  <= operation_i;
      id_q  <= trans_id_i;
    end
  end

  // --------------------
  // stage two
  // --------------------
  assign product = $signed(opa_q) * $signed(opb_q);

  // pick the part of the product the operation asks for
  always_comb begin
    unique case (op_q)
      muldiv_pkg::MULH, muldiv_pkg::MULHU, muldiv_pkg::MULHSU: begin
        result_d = product[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
      end
      // word multiply keeps the low 32 bits, sign extended
      muldiv_pkg::MULW: begin
        result_d = {{(`MULDIV_XLEN-32){product[31]}}, product[31:0]};
      end
      default: begin
        result_d = product[`MULDIV_XLEN-1:0];
      end
    endcase
  end

  // result pulse two edges after the issue edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_valid_o <= 1'b0;
    end else begin
      mult_valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      result_o        <= result_d;
      mult_trans_id_o <= id_q;
    end
  end

endmodule

`default_nettype wire

// ==== serdiv.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module serdiv (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  muldiv_pkg::trans_id_t id_i,
  input  muldiv_pkg::xlen_t     op_a_i,
  input  muldiv_pkg::xlen_t     op_b_i,
  // bit 1 selects remainder, bit 0 selects signed
  input  logic [1:0]            opcode_i,
  input  logic                  in_vld_i,
  input  logic                  out_rdy_i,
  output logic                  in_rdy_o,
  output logic                  out_vld_o,
  output muldiv_pkg::trans_id_t id_o,
  output muldiv_pkg::xlen_t     res_o
);

  // counter must hold the full width, so one bit more than log2
  localparam int unsigned cnt_bits = $clog2(`MULDIV_XLEN) + 1;

  // number of leading zero bits, full width for a zero value
  function automatic logic [cnt_bits-1:0] count_lz(input muldiv_pkg::xlen_t value);
    logic [cnt_bits-1:0] zeros;
    logic                found;
    zeros = '0;
    found = 1'b0;
    for (int i = `MULDIV_XLEN - 1; i >= 0; i--) begin
      if (value[i]) begin
        found = 1'b1;
      end else if (!found) begin
        zeros = zeros + 1'b1;
      end
    end
    return zeros;
  endfunction

  // --------------------
  // operand preparation
  // --------------------
  logic                   a_neg;
  logic                   b_neg;
  muldiv_pkg::xlen_t      a_abs;
  muldiv_pkg::xlen_t      b_abs;
  logic [cnt_bits-1:0]    a_lz;

  // signs only count for the signed forms
  assign a_neg = opcode_i[0] & op_a_i[`MULDIV_XLEN-1];
  assign b_neg = opcode_i[0] & op_b_i[`MULDIV_XLEN-1];
  // most negative value maps onto itself, which reads right as unsigned
  assign a_abs = a_neg ? -op_a_i : op_a_i;
  assign b_abs = b_neg ? -op_b_i : op_b_i;
  // leading zeros of the dividend give iterations we can skip
  assign a_lz  = count_lz(a_abs);

  // --------------------
  // state
  // --------------------
  muldiv_pkg::div_state_t state_d, state_q;
  logic [cnt_bits-1:0]    cnt_d, cnt_q;
  // partial remainder
  muldiv_pkg::xlen_t      prem_d, prem_q;
  // dividend bits shift out at the top, quotient bits shift in at the bottom
  muldiv_pkg::xlen_t      quot_d, quot_q;
  muldiv_pkg::xlen_t      dvsr_d, dvsr_q;
  muldiv_pkg::trans_id_t  id_d, id_q;
  logic                   rem_op_d, rem_op_q;
  logic                   q_neg_d, q_neg_q;
  logic                   r_neg_d, r_neg_q;

  // one restoring step, one bit wider so the shifted remainder never overflows
  logic [`MULDIV_XLEN:0]  prem_shift;
  logic [`MULDIV_XLEN:0]  prem_sub;
  logic                   prem_ge;

  assign prem_shift = {prem_q, quot_q[`MULDIV_XLEN-1]};
  assign prem_sub   = prem_shift - {1'b0, dvsr_q};
  assign prem_ge    = prem_shift >= {1'b0, dvsr_q};

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    prem_d   = prem_q;
    quot_d   = quot_q;
    dvsr_d   = dvsr_q;
    id_d     = id_q;
    rem_op_d = rem_op_q;
    q_neg_d  = q_neg_q;
    r_neg_d  = r_neg_q;

    unique case (state_q)
      muldiv_pkg::IDLE: begin
        if (in_vld_i) begin
          id_d     = id_i;
          rem_op_d = opcode_i[1];
          dvsr_d   = b_abs;
          if (op_b_i == '0) begin
            // divide by zero, all ones quotient and dividend as remainder
            quot_d  = '1;
            prem_d  = op_a_i;
            q_neg_d = 1'b0;
            r_neg_d = 1'b0;
            cnt_d   = '0;
            state_d = muldiv_pkg::FINISH;
          end else begin
            // left align the dividend so only its significant bits are processed
            quot_d  = a_abs << a_lz;
            prem_d  = '0;
            q_neg_d = a_neg ^ b_neg;
            r_neg_d = a_neg;
            cnt_d   = cnt_bits'(`MULDIV_XLEN) - a_lz;
            // zero dividend needs no steps at all
            if (a_lz == cnt_bits'(`MULDIV_XLEN)) begin
              state_d = muldiv_pkg::FINISH;
            end else begin
              state_d = muldiv_pkg::DIVIDE;
            end
          end
        end
      end
      muldiv_pkg::DIVIDE: begin
        prem_d = prem_ge ? prem_sub[`MULDIV_XLEN-1:0] : prem_shift[`MULDIV_XLEN-1:0];
        quot_d = {quot_q[`MULDIV_XLEN-2:0], prem_ge};
        cnt_d  = cnt_q - 1'b1;
        // last quotient bit goes in this cycle
        if (cnt_q == cnt_bits'(1)) begin
          state_d = muldiv_pkg::FINISH;
        end
      end
      muldiv_pkg::FINISH: begin
        // hold the result until the consumer side is free
        if (out_rdy_i) begin
          state_d = muldiv_pkg::IDLE;
        end
      end
      default: begin
        state_d = muldiv_pkg::IDLE;
      end
    endcase

    // flush drops whatever is in progress
    if (flush_i) begin
      state_d = muldiv_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= muldiv_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    prem_q   <= prem_d;
    quot_q   <= quot_d;
    dvsr_q   <= dvsr_d;
    id_q     <= id_d;
    rem_op_q <= rem_op_d;
    q_neg_q  <= q_neg_d;
    r_neg_q  <= r_neg_d;
  end

  // --------------------
  // outputs
  // --------------------
  // sign correction on the held magnitudes
  assign res_o     = rem_op_q ? (r_neg_q ? -prem_q : prem_q) : (q_neg_q ? -quot_q : quot_q);
  assign id_o      = id_q;
  assign in_rdy_o  = (state_q == muldiv_pkg::IDLE);
  assign out_vld_o = (state_q == muldiv_pkg::FINISH);

endmodule

`default_nettype wire

// ==== mult.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module mult (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  mult_valid_i,
  input  muldiv_pkg::fu_op_t    operation_i,
  input  muldiv_pkg::xlen_t     operand_a_i,
  input  muldiv_pkg::xlen_t     operand_b_i,
  input  muldiv_pkg::trans_id_t trans_id_i,
  output muldiv_pkg::xlen_t     result_o,
  output logic                  mult_valid_o,
  output logic                  mult_ready_o,
  output muldiv_pkg::trans_id_t mult_trans_id_o
);

  // sign extend the low word to the full width
  function automatic muldiv_pkg::xlen_t sext32(input muldiv_pkg::xlen_t value);
    return {{(`MULDIV_XLEN-32){value[31]}}, value[31:0]};
  endfunction

  logic                  is_mul_op;
  logic                  is_div_op;
  logic                  is_word_op;
  logic                  mul_valid_op;
  logic                  div_valid_op;
  logic                  mul_valid;
  logic                  div_valid;
  // low while the multiplier owns the result bus
  logic                  div_ready;
  muldiv_pkg::trans_id_t mul_trans_id;
  muldiv_pkg::trans_id_t div_trans_id;
  muldiv_pkg::xlen_t     mul_result;
  muldiv_pkg::xlen_t     div_raw;
  muldiv_pkg::xlen_t     div_result;

  // --------------------
  // input steering
  // --------------------
  assign is_mul_op = operation_i inside {muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHU,
                                         muldiv_pkg::MULHSU, muldiv_pkg::MULW};
  assign is_div_op = operation_i inside {muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::DIVW,
                                         muldiv_pkg::DIVUW, muldiv_pkg::REM, muldiv_pkg::REMU,
                                         muldiv_pkg::REMW, muldiv_pkg::REMUW};
  assign is_word_op = operation_i inside {muldiv_pkg::DIVW, muldiv_pkg::DIVUW, muldiv_pkg::REMW,
                                          muldiv_pkg::REMUW};

  // nothing new starts during a flush
  assign mul_valid_op = mult_valid_i & is_mul_op & ~flush_i;
  assign div_valid_op = mult_valid_i & is_div_op & ~flush_i;

  // --------------------
  // multiplier
  // --------------------
  // takes raw operands, it handles the word form itself
  multiplier i_multiplier (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mult_valid_i   (mul_valid_op),
    .operation_i    (operation_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .trans_id_i     (trans_id_i),
    .mult_valid_o   (mul_valid),
    .result_o       (mul_result),
    .mult_trans_id_o(mul_trans_id)
  );

  // --------------------
  // divider operands
  // --------------------
  muldiv_pkg::xlen_t div_op_a;
  muldiv_pkg::xlen_t div_op_b;
  logic              div_signed;
  logic              div_rem;
  logic              word_op_d, word_op_q;

  assign div_signed = operation_i inside {muldiv_pkg::DIV, muldiv_pkg::DIVW, muldiv_pkg::REM,
                                          muldiv_pkg::REMW};
  assign div_rem    = operation_i inside {muldiv_pkg::REM, muldiv_pkg::REMU, muldiv_pkg::REMW,
                                          muldiv_pkg::REMUW};

  always_comb begin
    // operands stay quiet unless a division is issued
    div_op_a  = '0;
    div_op_b  = '0;
    word_op_d = word_op_q;
    if (div_valid_op) begin
      if (is_word_op) begin
        // upper word is ignored, extension depends on signedness
        if (div_signed) begin
          div_op_a = sext32(operand_a_i);
          div_op_b = sext32(operand_b_i);
        end else begin
          div_op_a = {{(`MULDIV_XLEN-32){1'b0}}, operand_a_i[31:0]};
          div_op_b = {{(`MULDIV_XLEN-32){1'b0}}, operand_b_i[31:0]};
        end
        word_op_d = 1'b1;
      end else begin
        div_op_a  = operand_a_i;
        div_op_b  = operand_b_i;
        word_op_d = 1'b0;
      end
    end
  end

  // remembers the word form until the held result leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_op_q <= 1'b0;
    end else begin
      word_op_q <= word_op_d;
    end
  end

  // --------------------
  // serial divider
  // --------------------
  serdiv i_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .id_i     (trans_id_i),
    .op_a_i   (div_op_a),
    .op_b_i   (div_op_b),
    .opcode_i ({div_rem, div_signed}),
    .in_vld_i (div_valid_op),
    .out_rdy_i(div_ready),
    .in_rdy_o (mult_ready_o),
    .out_vld_o(div_valid),
    .id_o     (div_trans_id),
    .res_o    (div_raw)
  );

  // word results are always sign extended from bit 31
  assign div_result = word_op_q ? sext32(div_raw) : div_raw;

  // --------------------
  // output arbitration
  // --------------------
  // the multiplier cannot stall, so it always wins and the divider waits
  assign div_ready       = ~mul_valid;
  assign mult_valid_o    = mul_valid | div_valid;
  assign mult_trans_id_o = mul_valid ? mul_trans_id : div_trans_id;
  assign result_o        = mul_valid ? mul_result : div_result;

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // half of the 4 ns period
  localparam int half_period = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #half_period clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== mult_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module mult_tb;

  localparam int n_ids = 1 << `MULDIV_TRANS_ID_BITS;
  // operations per phase for the run limit
  localparam int n_mul    = 40;
  localparam int n_div    = 48;
  localparam int n_corner = 12;
  localparam int n_mix    = 4;
  localparam int n_flush  = 2;
  localparam int n_ops    = n_mul + n_div + n_corner + n_mix + n_flush;
  localparam int timeout_cycles = n_ops * (`MULDIV_XLEN + 8) + 200;
  localparam muldiv_pkg::xlen_t min_val = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  mult_valid_i;
  muldiv_pkg::fu_op_t    operation_i;
  muldiv_pkg::xlen_t     operand_a_i;
  muldiv_pkg::xlen_t     operand_b_i;
  muldiv_pkg::trans_id_t trans_id_i;
  muldiv_pkg::xlen_t     result_o;
  logic                  mult_valid_o;
  logic                  mult_ready_o;
  muldiv_pkg::trans_id_t mult_trans_id_o;

  integer seed = 18913;
  int     cyc;
  int     next_id;
  int     value_errors;
  int     id_errors;
  int     timing_errors;
  int     stim_errors;

  // --------------------
  // scoreboard with one slot per id
  // --------------------
  muldiv_pkg::xlen_t expected_tab [0:n_ids-1];
  logic              is_mul_tab [0:n_ids-1];
  int                issue_cyc [0:n_ids-1];
  int                done_cyc [0:n_ids-1];
  // a slot is pending when its issue count is neither retired nor cancelled
  int                issued_seq [0:n_ids-1];
  int                retired_seq [0:n_ids-1];
  int                cancelled_seq [0:n_ids-1];

  muldiv_pkg::fu_op_t mul_ops [0:4] = '{muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHU,
                                        muldiv_pkg::MULHSU, muldiv_pkg::MULW};
  muldiv_pkg::fu_op_t div_ops [0:7] = '{muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::DIVW,
                                        muldiv_pkg::DIVUW, muldiv_pkg::REM, muldiv_pkg::REMU,
                                        muldiv_pkg::REMW, muldiv_pkg::REMUW};

  tb_clock_gen i_clock_gen (
    .clk_o(clk_i)
  );

  mult DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .mult_valid_i   (mult_valid_i),
    .operation_i    (operation_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .trans_id_i     (trans_id_i),
    .result_o       (result_o),
    .mult_valid_o   (mult_valid_o),
    .mult_ready_o   (mult_ready_o),
    .mult_trans_id_o(mult_trans_id_o)
  );

  function automatic muldiv_pkg::xlen_t sign_extend_word(input muldiv_pkg::xlen_t value);
    return {{(`MULDIV_XLEN-32){value[31]}}, value[31:0]};
  endfunction

  function automatic logic is_multiply(input muldiv_pkg::fu_op_t op);
    return op inside {muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHU,
                      muldiv_pkg::MULHSU, muldiv_pkg::MULW};
  endfunction

  function automatic logic is_outstanding(input muldiv_pkg::trans_id_t id);
    return (issued_seq[id] != retired_seq[id]) && (issued_seq[id] != cancelled_seq[id]);
  endfunction

  // --------------------
  // reference model
  // --------------------
  // high halves come from a full 128-bit product of extended operands
  // divide by zero and overflow follow the RISC-V spec
  function automatic muldiv_pkg::xlen_t ref_result(input muldiv_pkg::fu_op_t op,
                                                   input muldiv_pkg::xlen_t a,
                                                   input muldiv_pkg::xlen_t b);
    logic [2*`MULDIV_XLEN-1:0]      wide;
    logic signed [`MULDIV_XLEN-1:0] sa;
    logic signed [`MULDIV_XLEN-1:0] sb;
    logic [31:0]                    ua_w;
    logic [31:0]                    ub_w;
    logic signed [31:0]             sa_w;
    logic signed [31:0]             sb_w;
    logic [31:0]                    w;
    logic                           ovf;
    logic                           ovf_w;
    muldiv_pkg::xlen_t              r;
    sa    = a;
    sb    = b;
    ua_w  = a[31:0];
    ub_w  = b[31:0];
    sa_w  = ua_w;
    sb_w  = ub_w;
    ovf   = (a == min_val) && (b == '1);
    ovf_w = (ua_w == 32'h8000_0000) && (ub_w == '1);
    w     = '0;
    r     = '0;
    case (op)
      muldiv_pkg::MUL:  r = a * b;
      muldiv_pkg::MULW: r = sign_extend_word(a * b);
      muldiv_pkg::MULH: begin
        wide = {{`MULDIV_XLEN{a[`MULDIV_XLEN-1]}}, a} * {{`MULDIV_XLEN{b[`MULDIV_XLEN-1]}}, b};
        r    = wide[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
      end
      muldiv_pkg::MULHU: begin
        wide = {{`MULDIV_XLEN{1'b0}}, a} * {{`MULDIV_XLEN{1'b0}}, b};
        r    = wide[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
      end
      muldiv_pkg::MULHSU: begin
        wide = {{`MULDIV_XLEN{a[`MULDIV_XLEN-1]}}, a} * {{`MULDIV_XLEN{1'b0}}, b};
        r    = wide[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
      end
      muldiv_pkg::DIV: begin
        if (b == '0) r = '1;
        else if (ovf) r = a;
        else r = sa / sb;
      end
      muldiv_pkg::DIVU: r = (b == '0) ? '1 : a / b;
      muldiv_pkg::REM: begin
        if (b == '0) r = a;
        else if (ovf) r = '0;
        else r = sa % sb;
      end
      muldiv_pkg::REMU: r = (b == '0) ? a : a % b;
      // word forms work on the low words and sign extend the 32-bit result
      muldiv_pkg::DIVW: begin
        if (ub_w == '0) w = '1;
        else if (ovf_w) w = ua_w;
        else w = sa_w / sb_w;
        r = sign_extend_word({32'h0, w});
      end
      muldiv_pkg::DIVUW: begin
        w = (ub_w == '0) ? '1 : ua_w / ub_w;
        r = sign_extend_word({32'h0, w});
      end
      muldiv_pkg::REMW: begin
        if (ub_w == '0) w = ua_w;
        else if (ovf_w) w = '0;
        else w = sa_w % sb_w;
        r = sign_extend_word({32'h0, w});
      end
      muldiv_pkg::REMUW: begin
        w = (ub_w == '0) ? ua_w : ua_w % ub_w;
        r = sign_extend_word({32'h0, w});
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // random operand mixed with corner values and often a garbage upper word
  function automatic muldiv_pkg::xlen_t pick_operand();
    logic [31:0]       hi;
    logic [31:0]       lo;
    int                sel;
    muldiv_pkg::xlen_t r;
    hi  = $random(seed);
    lo  = $random(seed);
    sel = $unsigned($random(seed)) % 8;
    case (sel)
      0:       r = '0;
      1:       r = 64'h1;
      2:       r = '1;
      3:       r = min_val;
      4:       r = {hi, 32'h8000_0000};
      5:       r = {56'h0, lo[7:0]};
      6:       r = {hi, 32'hffff_ffff};
      default: r = {hi, lo};
    endcase
    return r;
  endfunction

  // --------------------
  // result checker
  // --------------------
  always @(posedge clk_i) begin
    if (rst_ni && mult_valid_o) begin
      assert (is_outstanding(mult_trans_id_o)) else begin
        id_errors++;
        $display("ERROR: result for id %0d which is not outstanding, cycle %0d",
                 mult_trans_id_o, cyc);
      end
      if (is_outstanding(mult_trans_id_o)) begin
        assert (result_o === expected_tab[mult_trans_id_o]) else begin
          value_errors++;
          $display("FAILED result_o id %0d: expected %h, actual %h", mult_trans_id_o,
                   expected_tab[mult_trans_id_o], result_o);
        end
        // multiplier latency is fixed
        if (is_mul_tab[mult_trans_id_o]) begin
          assert (cyc - issue_cyc[mult_trans_id_o] == 2) else begin
            timing_errors++;
            $display("ERROR: multiply id %0d returned %0d cycles after issue instead of 2",
                     mult_trans_id_o, cyc - issue_cyc[mult_trans_id_o]);
          end
        end
        retired_seq[mult_trans_id_o] = issued_seq[mult_trans_id_o];
        done_cyc[mult_trans_id_o]    = cyc;
      end
    end
    cyc = cyc + 1;
  end

  task automatic finish_run(input bit timed_out);
    int total;
    total = value_errors + id_errors + timing_errors + stim_errors;
    $display("errors: value %0d, id %0d, timing %0d, other %0d, timeout %0d",
             value_errors, id_errors, timing_errors, stim_errors, timed_out);
    if (total == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // watchdog
  initial begin
    wait (cyc >= timeout_cycles);
    $display("ERROR: timeout, run did not end within %0d cycles", timeout_cycles);
    finish_run(1'b1);
  end

  // --------------------
  // stimulus tasks
  // --------------------
  // called at a falling edge and returns at the falling edge after the issue edge
  task automatic issue_op(input muldiv_pkg::fu_op_t op, input muldiv_pkg::xlen_t a,
                          input muldiv_pkg::xlen_t b, output muldiv_pkg::trans_id_t id);
    int cand;
    int k;
    assert (mult_ready_o) else begin
      stim_errors++;
      $display("ERROR: issue attempted while mult_ready_o is low");
    end
    // next id that is not pending
    cand = -1;
    for (k = 0; k < n_ids; k++) begin
      if (cand < 0 && !is_outstanding(muldiv_pkg::trans_id_t'((next_id + k) % n_ids))) begin
        cand = (next_id + k) % n_ids;
      end
    end
    if (cand < 0) begin
      stim_errors++;
      $display("ERROR: no free transaction id");
      cand = next_id;
    end
    next_id           = (cand + 1) % n_ids;
    id                = muldiv_pkg::trans_id_t'(cand);
    expected_tab[id]  = ref_result(op, a, b);
    is_mul_tab[id]    = is_multiply(op);
    issue_cyc[id]     = cyc;
    issued_seq[id]    = issued_seq[id] + 1;
    mult_valid_i      = 1'b1;
    operation_i       = op;
    operand_a_i       = a;
    operand_b_i       = b;
    trans_id_i        = id;
    @(negedge clk_i);
    mult_valid_i = 1'b0;
  endtask

  // divider must stay busy until its result is taken
  task automatic wait_result(input muldiv_pkg::trans_id_t id);
    int waited;
    waited = 0;
    while (is_outstanding(id) && waited < `MULDIV_XLEN + 8) begin
      assert (!mult_ready_o) else begin
        stim_errors++;
        $display("ERROR: mult_ready_o high while division id %0d is pending", id);
      end
      @(negedge clk_i);
      waited++;
    end
    assert (!is_outstanding(id) && waited <= `MULDIV_XLEN + 3) else begin
      stim_errors++;
      $display("ERROR: division id %0d took %0d cycles or never returned", id, waited);
    end
    assert (mult_ready_o) else begin
      stim_errors++;
      $display("ERROR: mult_ready_o did not return high after division id %0d", id);
    end
  endtask

  task automatic divide_and_wait(input muldiv_pkg::fu_op_t op, input muldiv_pkg::xlen_t a,
                                 input muldiv_pkg::xlen_t b);
    muldiv_pkg::trans_id_t id;
    issue_op(op, a, b, id);
    wait_result(id);
  endtask

  task automatic drain_all();
    int k;
    int busy;
    int waited;
    busy   = 1;
    waited = 0;
    while (busy != 0 && waited < 16) begin
      busy = 0;
      for (k = 0; k < n_ids; k++) begin
        if (is_outstanding(muldiv_pkg::trans_id_t'(k))) busy = 1;
      end
      if (busy != 0) begin
        @(negedge clk_i);
        waited++;
      end
    end
    assert (busy == 0) else begin
      stim_errors++;
      $display("ERROR: multiply results still missing after the stream");
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    muldiv_pkg::trans_id_t id;
    muldiv_pkg::trans_id_t mul_id;
    int                    k;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    mult_valid_i = 1'b0;
    operation_i  = muldiv_pkg::MUL;
    operand_a_i  = '0;
    operand_b_i  = '0;
    trans_id_i   = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // idle after reset
    assert (!mult_valid_o && mult_ready_o && !DUT.mul_valid && !DUT.div_valid) else begin
      stim_errors++;
      $display("ERROR: unit not idle after reset");
    end

    // back to back multiplies
    for (int i = 0; i < n_mul; i++) begin
      k = $unsigned($random(seed)) % 5;
      issue_op(mul_ops[k], pick_operand(), pick_operand(), id);
    end
    drain_all();

    // every divide kind in turn
    for (int i = 0; i < n_div; i++) begin
      divide_and_wait(div_ops[i % 8], pick_operand(), pick_operand());
    end

    // divide by zero with bit 31 of the dividend set
    for (int i = 0; i < 8; i++) begin
      divide_and_wait(div_ops[i], 64'hdead_beef_8765_4321, '0);
    end
    // signed overflow with garbage upper words on the word forms
    divide_and_wait(muldiv_pkg::DIV, min_val, '1);
    divide_and_wait(muldiv_pkg::REM, min_val, '1);
    divide_and_wait(muldiv_pkg::DIVW, 64'h1357_9bdf_8000_0000, 64'h2468_ace0_ffff_ffff);
    divide_and_wait(muldiv_pkg::REMW, 64'h1357_9bdf_8000_0000, 64'h2468_ace0_ffff_ffff);

    // multiply right before a division where the fast zero divide collides at the output
    issue_op(muldiv_pkg::MULHU, pick_operand(), pick_operand(), mul_id);
    issue_op(muldiv_pkg::DIVU, pick_operand(), '0, id);
    wait_result(id);
    assert (!is_outstanding(mul_id) && done_cyc[mul_id] < done_cyc[id]) else begin
      stim_errors++;
      $display("ERROR: multiply id %0d missing or not ahead of division id %0d", mul_id, id);
    end
    repeat (3) @(negedge clk_i);
    issue_op(muldiv_pkg::MULH, pick_operand(), pick_operand(), mul_id);
    issue_op(muldiv_pkg::DIV, pick_operand(), 64'h0000_0000_0001_2345, id);
    wait_result(id);
    assert (!is_outstanding(mul_id) && done_cyc[mul_id] < done_cyc[id]) else begin
      stim_errors++;
      $display("ERROR: multiply id %0d missing or not ahead of division id %0d", mul_id, id);
    end
    repeat (3) @(negedge clk_i);

    // flush a long division whose id must never come back
    issue_op(muldiv_pkg::DIVU, '1, 64'h3, id);
    repeat (4) @(negedge clk_i);
    flush_i           = 1'b1;
    cancelled_seq[id] = issued_seq[id];
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (mult_ready_o) else begin
      stim_errors++;
      $display("ERROR: mult_ready_o still low in the cycle after flush");
    end
    repeat (4) @(negedge clk_i);
    divide_and_wait(muldiv_pkg::DIV, pick_operand(), 64'h7);
    repeat (4) @(negedge clk_i);

    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
muldiv_pkg.sv
multiplier.sv
serdiv.sv
mult.sv
tb_clock_gen.sv
mult_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the multiply/divide testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module mult_tb \
  -f all.f \
  -o mult_tb_sim

./obj_dir/mult_tb_sim | tee sim.log

# the log decides the outcome
if grep -q "Test FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
